// ==== Makefile ====
# Verilator build and run for the s16b_main testbench

LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f s16b_main.f --top-module tb_s16b_main -Mdir obj_dir

run: compile
	./obj_dir/Vtb_s16b_main | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hw/cab_io.sv ====
// Cabinet I/O with video control, tile bank and input read port
`default_nettype none

module cab_io (
    input  logic                 clk,
    input  logic                 rst,
    cpu_bus_if.sink              bus,
    input  logic                 io_cs,
    input  logic                 tbank_cs,
    input  logic [7:0]           joystick1,
    input  logic [7:0]           joystick2,
    input  logic [7:0]           start_button,
    input  logic [7:0]           coin_input,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    input  logic                 service,
    input  logic                 dip_test,
    output s16b_pkg::word_t      io_dout,
    output logic                 flip,
    output logic                 video_en,
    output logic [5:0]           tile_bank
);
    import s16b_pkg::*;

    logic [7:0] sort1;
    logic [7:0] sort2;
    logic [7:0] cab_nxt;

    // Board wiring of the stick and buttons
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1], joy[0], joy[3], joy[2], joy[7], joy[5], joy[4], joy[6]};
    endfunction

    assign sort1 = sort_joy(joystick1);
    assign sort2 = sort_joy(joystick2);

    always_comb begin
        cab_nxt = io_idle;
        case (bus.addr[13:12])
            2'd1: begin
                case (bus.addr[2:1])
                    2'd0:    cab_nxt = {2'b11, start_button[1:0], service, dip_test,
                                        coin_input[1:0]};
                    2'd1:    cab_nxt = sort1;
                    2'd3:    cab_nxt = sort2;
                    default: cab_nxt = io_idle; // Players 3 and 4 not fitted
                endcase
            end
            2'd2:    cab_nxt = bus.addr[1] ? dipsw_a : dipsw_b;
            default: cab_nxt = io_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip      <= 1'b0;
            video_en  <= 1'b1;
            tile_bank <= '0;
            io_dout   <= {8'hff, io_idle};
        end else begin
            if (io_cs && bus.rnw)
                io_dout <= {8'hff, cab_nxt};
            // Video control sits at offset 0
            if (io_cs && !bus.lds_wn && bus.addr[13:12] == 2'd0) begin
                flip     <= bus.wdata[6];
                video_en <= bus.wdata[5];
            end
            if (tbank_cs && !bus.lds_wn) begin
                if (bus.addr[1])
                    tile_bank[5:3] <= bus.wdata[2:0];
                else
                    tile_bank[2:0] <= bus.wdata[2:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/cpu_bus_if.sv ====
// Captured CPU bus cycle from the select decoder to the cabinet I/O block
`default_nettype none

interface cpu_bus_if;
    import s16b_pkg::*;

    logic [23:1] addr;
    word_t       wdata;
    logic        rnw;
    logic        lds_wn; // Low only on a lower byte write
    logic        uds_wn; // Low only on an upper byte write

    modport source (
        output addr,
        output wdata,
        output rnw,
        output lds_wn,
        output uds_wn
    );

    modport sink (
        input addr,
        input wdata,
        input rnw,
        input lds_wn,
        input uds_wn
    );

endinterface

`default_nettype wire

// ==== hw/map_cfg_if.sv ====
// Mapper config bus from the register decoder to the region windows
`default_nettype none

interface map_cfg_if;
    import s16b_pkg::*;

    logic    we;    // One cycle per mapper write
    region_t idx;
    logic    field; // 0 base, 1 mask
    page_t   data;

    modport mapper (
        output we,
        output idx,
        output field,
        output data
    );

    modport window (
        input we,
        input idx,
        input field,
        input data
    );

endinterface

`default_nettype wire

// ==== hw/mapper_regs.sv ====
// Mapper register decode, turns writes to the mapper page into window config updates
`default_nettype none

module mapper_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 as_n,
    input  logic                 rnw,
    input  logic                 lds_n,
    input  logic [23:1]          addr,
    input  s16b_pkg::word_t      wdata,
    map_cfg_if.mapper            cfg,
    output logic                 map_ack
);
    import s16b_pkg::*;

    logic as_prev;

    // Start of a byte write to the mapper page
    assign map_ack = as_prev && !as_n && !rnw && !lds_n && addr[23:16] == mapper_page;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            as_prev <= 1'b1;
            cfg.we  <= 1'b0;
        end else begin
            as_prev <= as_n;
            cfg.we  <= map_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (map_ack) begin
            cfg.idx   <= addr[4:2];
            cfg.field <= addr[1];    // Odd word selects the mask
            cfg.data  <= wdata[7:0];
        end
    end

    // One config update per bus cycle at most
    a_one_we_per_cycle: assert property (
        @(posedge clk) disable iff (rst)
        cfg.we |=> (!cfg.we until as_n)
    ) else $error("mapper write pulsed twice in one bus cycle");

endmodule

`default_nettype wire

// ==== hw/region_window.sv ====
// Mapper region window, matches the bus page against a programmable base and mask
`default_nettype none

module region_window #(
    parameter s16b_pkg::region_t idx = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    map_cfg_if.window            cfg,
    input  s16b_pkg::page_t      page,
    output logic                 hit
);
    import s16b_pkg::*;

    page_t base;
    page_t mask;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base <= reset_base[idx];
            mask <= reset_mask[idx];
        end else if (cfg.we && cfg.idx == idx) begin
            if (cfg.field)
                mask <= cfg.data;
            else
                base <= cfg.data;
        end
    end

    // Masked-out bits are don't care
    assign hit = ((page ^ base) & mask) == '0;

    // A ROM window with an empty mask would swallow the whole map
    a_rom_mask_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        (idx < reg_ram && cfg.we && cfg.idx == idx && cfg.field) |-> cfg.data != '0
    ) else $error("zero mask written to ROM region %0d", idx);

endmodule

`default_nettype wire

// ==== hw/s16b_main.sv ====
// System 16B main board decode and I/O top level
`default_nettype none

module s16b_main (
    input  logic                 clk,
    input  logic                 rst,
    // CPU bus
    input  logic                 as_n,
    input  logic                 uds_n,
    input  logic                 lds_n,
    input  logic                 rnw,
    input  logic [23:1]          addr,
    input  s16b_pkg::word_t      wdata,
    output s16b_pkg::word_t      cpu_din,
    output logic                 dtack_n,
    // Program ROM
    output logic                 rom_cs,
    output s16b_pkg::rom_addr_t  rom_addr,
    input  s16b_pkg::word_t      rom_data,
    input  logic                 rom_ok,
    // Work RAM and tile RAM
    output logic                 ram_cs,
    output logic                 vram_cs,
    input  s16b_pkg::word_t      ram_data,
    input  logic                 ram_ok,
    // Video memories
    output logic                 char_cs,
    output logic                 pal_cs,
    output logic                 objram_cs,
    input  s16b_pkg::word_t      char_dout,
    input  s16b_pkg::word_t      pal_dout,
    input  s16b_pkg::word_t      obj_dout,
    // Cabinet
    input  logic [7:0]           joystick1,
    input  logic [7:0]           joystick2,
    input  logic [7:0]           start_button,
    input  logic [7:0]           coin_input,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    input  logic                 service,
    input  logic                 dip_test,
    output logic                 flip,
    output logic                 video_en,
    output logic [5:0]           tile_bank
);
    import s16b_pkg::*;

    logic [num_regions-1:0] hits;
    logic                   map_ack;
    logic                   io_cs;
    logic                   tbank_cs;
    word_t                  io_dout;

    map_cfg_if cfg_if ();
    cpu_bus_if bus_if ();

    mapper_regs u_mapper (
        .clk     (clk),
        .rst     (rst),
        .as_n    (as_n),
        .rnw     (rnw),
        .lds_n   (lds_n),
        .addr    (addr),
        .wdata   (wdata),
        .cfg     (cfg_if.mapper),
        .map_ack (map_ack)
    );

    for (genvar i = 0; i < num_regions; i++) begin : g_win
        region_window #(
            .idx (region_t'(i))
        ) u_win (
            .clk  (clk),
            .rst  (rst),
            .cfg  (cfg_if.window),
            .page (addr[23:16]),
            .hit  (hits[i])
        );
    end

    sel_decoder u_dec (
        .clk       (clk),
        .rst       (rst),
        .as_n      (as_n),
        .uds_n     (uds_n),
        .lds_n     (lds_n),
        .rnw       (rnw),
        .addr      (addr),
        .wdata     (wdata),
        .hits      (hits),
        .map_ack   (map_ack),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .io_dout   (io_dout),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .tbank_cs  (tbank_cs),
        .rom_addr  (rom_addr),
        .cpu_din   (cpu_din),
        .dtack_n   (dtack_n),
        .bus       (bus_if.source)
    );

    cab_io u_io (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus_if.sink),
        .io_cs        (io_cs),
        .tbank_cs     (tbank_cs),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .service      (service),
        .dip_test     (dip_test),
        .io_dout      (io_dout),
        .flip         (flip),
        .video_en     (video_en),
        .tile_bank    (tile_bank)
    );

endmodule

`default_nettype wire

// ==== hw/s16b_pkg.sv ====
// System 16B decode package with region roles, mapper page, reset map and bus types
`default_nettype none

package s16b_pkg;

    localparam int num_regions = 8;

    typedef logic [7:0]  page_t;     // CPU address bits 23:16
    typedef logic [15:0] word_t;
    typedef logic [2:0]  region_t;
    typedef logic [17:0] rom_addr_t; // ROM word address

    // Region roles, regions 0 to 2 hold program ROM
    localparam region_t reg_ram  = 3'd3;
    localparam region_t reg_oram = 3'd4;
    localparam region_t reg_vram = 3'd5; // Text and tile RAM
    localparam region_t reg_pal  = 3'd6;
    localparam region_t reg_io   = 3'd7;

    localparam page_t mapper_page = 8'hff;

    // Map after reset
    localparam page_t reset_base [num_regions] = '{
        8'h00, // ROM 0
        8'h08, // ROM 1
        8'h10, // ROM 2
        8'hc0, // Work RAM
        8'h44, // Object RAM
        8'h40, // Text/tile RAM
        8'h84, // Palette
        8'hc4  // Cabinet I/O
    };

    localparam page_t reset_mask [num_regions] = '{
        8'hf8,
        8'hf8,
        8'hf8,
        8'hff,
        8'hff,
        8'hfe, // Two pages, A16 picks text or tile
        8'hff,
        8'hff
    };

    localparam logic [7:0] io_idle = 8'hff; // Undriven cabinet lines read high

endpackage

`default_nettype wire

// ==== hw/sel_decoder.sv ====
// Chip select decoder with ROM banking, registered read mux and bus acknowledge
`default_nettype none

module sel_decoder (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           as_n,
    input  logic                           uds_n,
    input  logic                           lds_n,
    input  logic                           rnw,
    input  logic [23:1]                    addr,
    input  s16b_pkg::word_t                wdata,
    input  logic [s16b_pkg::num_regions-1:0] hits,
    input  logic                           map_ack,
    input  logic                           rom_ok,
    input  logic                           ram_ok,
    input  s16b_pkg::word_t                rom_data,
    input  s16b_pkg::word_t                ram_data,
    input  s16b_pkg::word_t                char_dout,
    input  s16b_pkg::word_t                pal_dout,
    input  s16b_pkg::word_t                obj_dout,
    input  s16b_pkg::word_t                io_dout,
    output logic                           rom_cs,
    output logic                           ram_cs,
    output logic                           vram_cs,
    output logic                           char_cs,
    output logic                           pal_cs,
    output logic                           objram_cs,
    output logic                           io_cs,
    output logic                           tbank_cs,
    output s16b_pkg::rom_addr_t            rom_addr,
    output s16b_pkg::word_t                cpu_din,
    output logic                           dtack_n,
    cpu_bus_if.source                      bus
);
    import s16b_pkg::*;

    logic    as_prev;
    logic    any_hit;
    region_t win;
    logic    io_dly;  // I/O needs one extra cycle
    logic    ack;
    word_t   din_nxt;

    // Lowest numbered window wins
    always_comb begin
        win     = '0;
        any_hit = 1'b0;
        for (int i = num_regions - 1; i >= 0; i--) begin
            if (hits[i]) begin
                win     = region_t'(i);
                any_hit = 1'b1;
            end
        end
        if (addr[23:16] == mapper_page)
            any_hit = 1'b0; // Mapper registers live here
    end

    // Latch the bus at the start of each cycle
    always_ff @(posedge clk) begin
        if (as_prev && !as_n) begin
            bus.addr   <= addr;
            bus.wdata  <= wdata;
            bus.rnw    <= rnw;
            bus.lds_wn <= rnw | lds_n;
            bus.uds_wn <= rnw | uds_n;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end else if (as_n) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end else begin
            rom_cs    <= any_hit && win < reg_ram && rnw;
            tbank_cs  <= any_hit && win == region_t'(2) && !rnw; // Tile bank sits on ROM 2
            ram_cs    <= any_hit && win == reg_ram;
            vram_cs   <= any_hit && win == reg_vram && !addr[16];
            char_cs   <= any_hit && win == reg_vram && addr[16];
            objram_cs <= any_hit && win == reg_oram;
            pal_cs    <= any_hit && win == reg_pal;
            io_cs     <= any_hit && win == reg_io;
        end
    end

    // 512kB of ROM, region bit 0 picks the half
    always_ff @(posedge clk) begin
        if (!as_n)
            rom_addr <= {win[0], addr[17:1]};
    end

    always_comb begin
        ack     = 1'b0;
        din_nxt = cpu_din;
        if (rom_cs && rom_ok) begin
            ack     = 1'b1;
            din_nxt = rom_data; // No decryption
        end else if ((ram_cs || vram_cs) && ram_ok) begin
            ack     = 1'b1;
            din_nxt = ram_data;
        end else if (char_cs) begin
            ack     = 1'b1;
            din_nxt = char_dout;
        end else if (pal_cs) begin
            ack     = 1'b1;
            din_nxt = pal_dout;
        end else if (objram_cs) begin
            ack     = 1'b1;
            din_nxt = obj_dout;
        end else if (io_cs && io_dly) begin
            ack     = 1'b1;
            din_nxt = io_dout;
        end else if (tbank_cs || map_ack) begin
            ack     = 1'b1; // Write only
        end
    end

    // Data is captured with the acknowledge and held to the end of the cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            as_prev <= 1'b1;
            io_dly  <= 1'b0;
            dtack_n <= 1'b1;
            cpu_din <= 16'hffff;
        end else begin
            as_prev <= as_n;
            io_dly  <= io_cs;
            if (as_n) begin
                dtack_n <= 1'b1;
            end else if (dtack_n && ack) begin
                dtack_n <= 1'b0;
                cpu_din <= din_nxt;
            end
        end
    end

    a_cs_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs, tbank_cs})
    ) else $error("more than one chip select active");

endmodule

`default_nettype wire

// ==== s16b_main.f ====
+incdir+test
hw/s16b_pkg.sv
hw/map_cfg_if.sv
hw/cpu_bus_if.sv
hw/mapper_regs.sv
hw/region_window.sv
hw/sel_decoder.sv
hw/cab_io.sv
hw/s16b_main.sv
test/tb_s16b_main.sv

// ==== test/tb_model.svh ====
// Reference model of the address map, joystick wiring and cabinet reads, plus typed compare tasks
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

    // Map as the testbench believes it to be
    page_t map_base [8] = '{8'h00, 8'h08, 8'h10, 8'hc0, 8'h44, 8'h40, 8'h84, 8'hc4};
    page_t map_mask [8] = '{8'hf8, 8'hf8, 8'hf8, 8'hff, 8'hff, 8'hfe, 8'hff, 8'hff};

    // Lowest matching window, -1 when nothing answers
    function automatic int model_win(input page_t p);
        if (p == 8'hff)
            return -1;
        for (int i = 0; i < 8; i++) begin
            if ((p & map_mask[i]) == (map_base[i] & map_mask[i]))
                return i;
        end
        return -1;
    endfunction

    function automatic logic [7:0] model_cs(input logic [23:0] baddr, input logic rd);
        logic [7:0] cs;
        int         w;
        cs = '0;
        w  = model_win(baddr[23:16]);
        case (w)
            0, 1:    cs[cs_rom] = rd;
            2:       cs[rd ? cs_rom : cs_tbank] = 1'b1;
            3:       cs[cs_ram] = 1'b1;
            4:       cs[cs_obj] = 1'b1;
            5:       cs[baddr[16] ? cs_char : cs_vram] = 1'b1;
            6:       cs[cs_pal] = 1'b1;
            7:       cs[cs_io] = 1'b1;
            default: cs = '0;
        endcase
        return cs;
    endfunction

    function automatic logic [7:0] sort_model(input logic [7:0] joy);
        int         order [8] = '{1, 0, 3, 2, 7, 5, 4, 6};
        logic [7:0] s;
        for (int i = 0; i < 8; i++)
            s[7 - i] = joy[order[i]];
        return s;
    endfunction

    function automatic logic [7:0] cab_model(input logic [23:0] baddr);
        if (baddr[13:12] == 2'd2)
            return baddr[1] ? dipsw_a : dipsw_b;
        if (baddr[13:12] != 2'd1)
            return 8'hff;
        case (baddr[2:1])
            2'd0:    return {2'b11, start_button[1:0], service, dip_test, coin_input[1:0]};
            2'd1:    return sort_model(joystick1);
            2'd3:    return sort_model(joystick2);
            default: return 8'hff;
        endcase
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_rom_addr(input string what, input rom_addr_t exp, input rom_addr_t act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s %s expected %b actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

`endif

// ==== test/tb_s16b_main.sv ====
// Testbench for the System 16B decode and I/O block with random bus traffic and a map model
`default_nettype none

module tb_s16b_main;
    timeunit 1ns;
    timeprecision 1ps;
    import s16b_pkg::*;

    // Bit positions in the select vector
    localparam int cs_rom   = 7;
    localparam int cs_ram   = 6;
    localparam int cs_vram  = 5;
    localparam int cs_char  = 4;
    localparam int cs_pal   = 3;
    localparam int cs_obj   = 2;
    localparam int cs_io    = 1;
    localparam int cs_tbank = 0;

    logic clk = 1'b0;
    logic rst, as_n, uds_n, lds_n, rnw, rom_ok, ram_ok, service, dip_test;
    logic [23:1] addr;
    word_t wdata, cpu_din, rom_data, ram_data, char_dout, pal_dout, obj_dout;
    logic dtack_n, rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, flip, video_en;
    rom_addr_t rom_addr;
    logic [7:0] joystick1, joystick2, start_button, coin_input, dipsw_a, dipsw_b;
    logic [5:0] tile_bank;

    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_bad = 0;
    int    test_err0 = 0;
    string cur_test = "";
    string cs_names [8] = '{"tbank_cs", "io_cs", "objram_cs", "pal_cs", "char_cs", "vram_cs",
                            "ram_cs", "rom_cs"};
    logic [15:0] lfsr = 16'd70;
    logic       flip_m, ven_m;
    logic [5:0] bank_m;

    `include "tb_model.svh"

    s16b_main u_dut (.*);

    always #4 clk = ~clk;

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [7:0] cs_now();
        return {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, u_dut.io_cs, u_dut.tbank_cs};
    endfunction

    function automatic word_t expected_din(input logic [7:0] cs, input logic [23:0] baddr);
        if (cs[cs_rom])
            return rom_data;
        if (cs[cs_ram] || cs[cs_vram])
            return ram_data;
        if (cs[cs_char])
            return char_dout;
        if (cs[cs_pal])
            return pal_dout;
        if (cs[cs_obj])
            return obj_dout;
        return {8'hff, cab_model(baddr)};
    endfunction

    // One 68000 style bus cycle, memories raise ok after dly cycles of select
    task automatic bus_cycle(input logic [23:0] baddr, input logic rd, input word_t wd,
                             input int dly, input int limit, output logic acked,
                             output logic [7:0] seen, output word_t din, output rom_addr_t ra);
        int n;
        int left;
        left  = dly;
        acked = 1'b0;
        seen  = '0;
        din   = '0;
        ra    = '0;
        addr  = baddr[23:1];
        rnw   = rd;
        wdata = wd;
        uds_n = 1'b0;
        lds_n = 1'b0;
        as_n  = 1'b0;
        n     = 0;
        while (!acked && n < limit) begin
            @(posedge clk);
            #1;
            n++;
            seen |= cs_now();
            if (rom_cs)
                ra = rom_addr;
            if (!dtack_n) begin
                acked = 1'b1;
                din   = cpu_din;
                // ROM and RAM must not answer before their ok level
                if ((seen[cs_rom] || seen[cs_ram] || seen[cs_vram]) && !rom_ok) begin
                    $display("dtack_n fell at %h before the memory raised ok", baddr);
                    errors++;
                end
            end else if (rom_cs || ram_cs || vram_cs) begin
                if (left == 0) begin
                    rom_ok = 1'b1;
                    ram_ok = 1'b1;
                end else begin
                    left--;
                end
            end
        end
        as_n   = 1'b1;
        uds_n  = 1'b1;
        lds_n  = 1'b1;
        rnw    = 1'b1;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        n      = 0;
        while (dtack_n !== 1'b1 && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (dtack_n !== 1'b1) begin
            $display("dtack_n stayed low after the bus cycle at %h ended", baddr);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic access(input logic [23:0] baddr, input logic rd, input word_t wd);
        logic [7:0] exp_cs;
        logic       acked;
        logic [7:0] seen;
        word_t      din;
        rom_addr_t  ra;
        int         w;
        exp_cs = model_cs(baddr, rd);
        w      = model_win(baddr[23:16]);
        bus_cycle(baddr, rd, wd, int'(rand_bits(3)), (exp_cs != 0) ? 40 : 20, acked, seen, din, ra);
        if (exp_cs != 0 && !acked) begin
            $display("timeout waiting for dtack_n on access to %h", baddr);
            errors++;
        end else begin
            check_bit($sformatf("dtack at %h", baddr), exp_cs != 0, acked);
        end
        for (int i = 0; i < 8; i++)
            check_bit($sformatf("%s at %h", cs_names[i], baddr), exp_cs[i], seen[i]);
        if (acked && rd)
            check_word($sformatf("cpu_din at %h", baddr), expected_din(exp_cs, baddr), din);
        if (exp_cs[cs_rom])
            check_rom_addr("rom_addr", {w[0], baddr[17:1]}, ra);
    endtask

    task automatic mapper_write(input int idx, input logic field, input page_t data);
        logic       acked;
        logic [7:0] seen;
        word_t      din;
        rom_addr_t  ra;
        bus_cycle(24'(24'hff0000 | (idx << 2) | (field << 1)), 1'b0, {8'h00, data}, 0, 20,
                  acked, seen, din, ra);
        check_bit("mapper dtack", 1'b1, acked);
        if (field)
            map_mask[idx] = data;
        else
            map_base[idx] = data;
    endtask

    task automatic randomize_sources();
        rom_data  = 16'(rand_bits(16));
        ram_data  = 16'(rand_bits(16));
        char_dout = 16'(rand_bits(16));
        pal_dout  = 16'(rand_bits(16));
        obj_dout  = 16'(rand_bits(16));
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_err0)
            tests_bad++;
        $display("test %s: %0d errors", cur_test, errors - test_err0);
    endtask

    initial begin
        logic [23:0] a;
        page_t       old_p;
        int          r;
        {as_n, uds_n, lds_n, rnw} = 4'hf;
        {rom_ok, ram_ok, service, dip_test} = 4'h0;
        addr = '0;
        wdata = '0;
        {joystick1, joystick2, start_button, coin_input, dipsw_a, dipsw_b} = '1;
        randomize_sources();
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("reset_unmapped");
        check_bit("rom_cs", 1'b0, rom_cs);
        check_bit("ram_cs", 1'b0, ram_cs);
        check_bit("vram_cs", 1'b0, vram_cs);
        check_bit("char_cs", 1'b0, char_cs);
        check_bit("pal_cs", 1'b0, pal_cs);
        check_bit("objram_cs", 1'b0, objram_cs);
        check_bit("dtack_n", 1'b1, dtack_n);
        check_bit("flip", 1'b0, flip);
        check_bit("video_en", 1'b1, video_en);
        check_word("tile_bank", 16'h0000, {10'd0, tile_bank});
        check_word("cpu_din", 16'hffff, cpu_din);
        for (int i = 0; i < 6; i++)
            access({8'h18 + 8'(rand_bits(5)), 16'(rand_bits(16))} & 24'hfffffe, 1'b1, '0);
        end_test();

        start_test("rom_reads");
        for (int i = 0; i < 16; i++) begin
            randomize_sources();
            access({8'(rand_bits(5) % 24), 15'(rand_bits(15)), 1'b0}, 1'b1, '0);
        end
        end_test();

        start_test("ram_video_reads");
        for (int i = 0; i < 20; i++) begin
            randomize_sources();
            case (rand_bits(2))
                0:       a = {8'hc0, 16'h0};
                1:       a = {8'h40 | 8'(rand_bits(1)), 16'h0};
                2:       a = {8'h44, 16'h0};
                default: a = {8'h84, 16'h0};
            endcase
            access(a | {8'h00, 15'(rand_bits(15)), 1'b0}, 1'b1, '0);
        end
        end_test();

        start_test("io_writes");
        bank_m = '0;
        for (int i = 0; i < 8; i++) begin
            wdata = 16'(rand_bits(16));
            access({8'hc4, 2'b00, 2'b00, 11'(rand_bits(11)), 1'b0}, 1'b0, wdata);
            flip_m = wdata[6];
            ven_m  = wdata[5];
            check_bit("flip", flip_m, flip);
            check_bit("video_en", ven_m, video_en);
            a = {8'h10 | 8'(rand_bits(3)), 14'(rand_bits(14)), 1'(rand_bits(1)), 1'b0};
            wdata = 16'(rand_bits(16));
            access(a, 1'b0, wdata);
            if (a[1])
                bank_m[5:3] = wdata[2:0];
            else
                bank_m[2:0] = wdata[2:0];
            check_word("tile_bank", {10'd0, bank_m}, {10'd0, tile_bank});
            access({8'hc4, 2'b00, 2'(rand_bits(2) % 3 + 1), 11'(rand_bits(11)), 1'b0}, 1'b1, '0);
            check_bit("flip kept", flip_m, flip);
            check_bit("video_en kept", ven_m, video_en);
            check_word("tile_bank kept", {10'd0, bank_m}, {10'd0, tile_bank});
        end
        end_test();

        start_test("cabinet_reads");
        for (int i = 0; i < 16; i++) begin
            joystick1    = 8'(rand_bits(8));
            joystick2    = 8'(rand_bits(8));
            start_button = 8'(rand_bits(8));
            coin_input   = 8'(rand_bits(8));
            dipsw_a      = 8'(rand_bits(8));
            dipsw_b      = 8'(rand_bits(8));
            service      = 1'(rand_bits(1));
            dip_test     = 1'(rand_bits(1));
            a = {8'hc4, 2'b00, 2'(rand_bits(2)), 9'(rand_bits(9)), 2'(rand_bits(2)), 1'b0};
            if (a[13:12] == 2'd0)
                a[12] = 1'b1; // Keep the video register untouched
            access(a, 1'b1, '0);
        end
        end_test();

        start_test("remap");
        for (int i = 0; i < 4; i++) begin
            r     = 3 + int'(rand_bits(2));
            old_p = map_base[r];
            mapper_write(r, 1'b1, 8'hff);
            mapper_write(r, 1'b0, 8'h20 + 8'(rand_bits(5)));
            randomize_sources();
            access({map_base[r], 15'(rand_bits(15)), 1'b0}, 1'b1, '0);
            access({old_p, 15'(rand_bits(15)), 1'b0}, 1'b1, '0);
        end
        end_test();

        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
